/* logic/isaPkg.sv */
package isaPkg;

  // raw 32-bit instruction word, no compressed forms
  typedef logic [31:0] instrT;

  // major opcode field, bits 6:0
  typedef logic [6:0] opcodeT;

  // architectural register index, x0 to x31
  typedef logic [4:0] regIdxT;

  // upper immediate forms
  localparam opcodeT OP_LUI = 7'b0110111;
  localparam opcodeT OP_AUIPC = 7'b0010111;

  // control transfer
  localparam opcodeT OP_JAL = 7'b1101111;
  localparam opcodeT OP_JALR = 7'b1100111;
  localparam opcodeT OP_BRANCH = 7'b1100011;

  // memory access
  localparam opcodeT OP_LOAD = 7'b0000011;
  localparam opcodeT OP_STORE = 7'b0100011;

  // integer compute, register-immediate and register-register
  localparam opcodeT OP_IMM = 7'b0010011;
  localparam opcodeT OP_REG = 7'b0110011;

endpackage

/* logic/frontPkg.sv */
package frontPkg;

  // fetch lanes per bundle
  localparam int FETCH_WIDTH = 2;
  // a lane can crack into link + jump
  localparam int UOPS_PER_LANE = 2;
  // decode output slots feeding the buffer
  localparam int SLOT_COUNT = FETCH_WIDTH * UOPS_PER_LANE;
  // micro-ops offered to rename per cycle
  localparam int DISPATCH_WIDTH = 2;
  // buffer entries, power of two so pointers wrap for free
  localparam int IB_DEPTH = 16;

  // buffer pointer and occupancy, count needs one more bit
  typedef logic [3:0] ibPtrT;
  typedef logic [4:0] ibCountT;

  // pc and sign-extended immediate
  typedef logic [31:0] addrT;
  typedef logic [31:0] immT;

  // micro-op class codes
  typedef logic [2:0] uopClassT;
  localparam uopClassT UOP_ALU = 3'd0;
  localparam uopClassT UOP_BRANCH = 3'd1;
  localparam uopClassT UOP_JUMP = 3'd2;
  localparam uopClassT UOP_LOAD = 3'd3;
  localparam uopClassT UOP_STORE = 3'd4;
  localparam uopClassT UOP_LINK = 3'd5;
  localparam uopClassT UOP_ILLEGAL = 3'd6;

  // decode control states
  typedef enum logic {
    CTRL_FLUSH,
    CTRL_RUN
  } ctrlStateT;

endpackage

/* logic/decodeLane.sv */
module decodeLane (
  input  isaPkg::instrT      instr_i,
  input  frontPkg::addrT     pc_i,
  input  logic               laneValid_i,
  output logic               uop0Valid_o,
  output frontPkg::uopClassT uop0Class_o,
  output isaPkg::regIdxT     uop0Dst_o,
  output isaPkg::regIdxT     uop0Src1_o,
  output isaPkg::regIdxT     uop0Src2_o,
  output frontPkg::immT      uop0Imm_o,
  output logic               uop1Valid_o,
  output frontPkg::uopClassT uop1Class_o,
  output isaPkg::regIdxT     uop1Dst_o,
  output isaPkg::regIdxT     uop1Src1_o,
  output isaPkg::regIdxT     uop1Src2_o,
  output frontPkg::immT      uop1Imm_o
);
  import isaPkg::*;
  import frontPkg::*;

  opcodeT opcode;
  regIdxT rd;
  regIdxT rs1;
  regIdxT rs2;
  immT immI;
  immT immS;
  immT immB;
  immT immU;
  immT immJ;
  // jump uop fields, shared by the cracked and single forms
  regIdxT jumpSrc1;
  immT jumpImm;
  logic pcMisaligned;

  // fixed field positions
  assign opcode = instr_i[6:0];
  assign rd = instr_i[11:7];
  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  // immediates per format, all sign-extended from bit 31
  assign immI = {{20{instr_i[31]}}, instr_i[31:20]};
  assign immS = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign immB = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                 instr_i[11:8], 1'b0};
  assign immU = {instr_i[31:12], 12'b0};
  assign immJ = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                 instr_i[30:21], 1'b0};

  // jalr reads rs1 with an I offset, jal is pc relative
  assign jumpSrc1 = (opcode == OP_JALR) ? rs1 : '0;
  assign jumpImm = (opcode == OP_JALR) ? immI : immJ;

  // no compressed support, so low pc bits must be zero
  assign pcMisaligned = |pc_i[1:0];

  always_comb
  begin
    // default is one illegal uop in slot 0, slot 1 empty
    uop0Valid_o = laneValid_i;
    uop0Class_o = UOP_ILLEGAL;
    uop0Dst_o = '0;
    uop0Src1_o = '0;
    uop0Src2_o = '0;
    uop0Imm_o = '0;
    uop1Valid_o = 1'b0;
    uop1Class_o = UOP_ALU;
    uop1Dst_o = '0;
    uop1Src1_o = '0;
    uop1Src2_o = '0;
    uop1Imm_o = '0;
    if (!pcMisaligned)
    begin
      case (opcode)
        OP_LUI, OP_AUIPC:
        begin
          uop0Class_o = UOP_ALU;
          uop0Dst_o = rd;
          uop0Imm_o = immU;
        end
        OP_IMM:
        begin
          uop0Class_o = UOP_ALU;
          uop0Dst_o = rd;
          uop0Src1_o = rs1;
          uop0Imm_o = immI;
        end
        OP_REG:
        begin
          uop0Class_o = UOP_ALU;
          uop0Dst_o = rd;
          uop0Src1_o = rs1;
          uop0Src2_o = rs2;
        end
        OP_LOAD:
        begin
          uop0Class_o = UOP_LOAD;
          uop0Dst_o = rd;
          uop0Src1_o = rs1;
          uop0Imm_o = immI;
        end
        OP_STORE:
        begin
          uop0Class_o = UOP_STORE;
          uop0Src1_o = rs1;
          uop0Src2_o = rs2;
          uop0Imm_o = immS;
        end
        OP_BRANCH:
        begin
          uop0Class_o = UOP_BRANCH;
          uop0Src1_o = rs1;
          uop0Src2_o = rs2;
          uop0Imm_o = immB;
        end
        OP_JAL, OP_JALR:
        begin
          if (rd != '0)
          begin
            // link writes pc+4 to rd, jump follows in slot 1
            uop0Class_o = UOP_LINK;
            uop0Dst_o = rd;
            uop0Imm_o = 32'd4;
            uop1Valid_o = laneValid_i;
            uop1Class_o = UOP_JUMP;
            uop1Src1_o = jumpSrc1;
            uop1Imm_o = jumpImm;
          end
          else
          begin
            // rd is x0, nothing to link
            uop0Class_o = UOP_JUMP;
            uop0Src1_o = jumpSrc1;
            uop0Imm_o = jumpImm;
          end
        end
        default:
        begin
          uop0Class_o = UOP_ILLEGAL;
        end
      endcase
    end
  end

endmodule

/* logic/decodeStage.sv */
module decodeStage (
  input  logic                                           fetchValid_i,
  input  logic [frontPkg::FETCH_WIDTH-1:0]               laneActive_i,
  input  frontPkg::addrT [frontPkg::FETCH_WIDTH-1:0]     fetchPc_i,
  input  isaPkg::instrT [frontPkg::FETCH_WIDTH-1:0]      fetchInstr_i,
  output logic [frontPkg::SLOT_COUNT-1:0]                slotValid_o,
  output frontPkg::uopClassT [frontPkg::SLOT_COUNT-1:0]  slotClass_o,
  output isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]      slotDst_o,
  output isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]      slotSrc1_o,
  output isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]      slotSrc2_o,
  output frontPkg::immT [frontPkg::SLOT_COUNT-1:0]       slotImm_o,
  output frontPkg::addrT [frontPkg::SLOT_COUNT-1:0]      slotPc_o
);
  import frontPkg::*;

  // one decoder per fetch lane, lane g fills slots 2g and 2g+1
  for (genvar g = 0; g < FETCH_WIDTH; g++)
  begin : laneGen
    logic laneValid;

    // switched-off lanes and idle fetch produce no uops
    assign laneValid = fetchValid_i & laneActive_i[g];

    decodeLane decodeLane_i (
      .instr_i     (fetchInstr_i[g]),
      .pc_i        (fetchPc_i[g]),
      .laneValid_i (laneValid),
      .uop0Valid_o (slotValid_o[UOPS_PER_LANE*g]),
      .uop0Class_o (slotClass_o[UOPS_PER_LANE*g]),
      .uop0Dst_o   (slotDst_o[UOPS_PER_LANE*g]),
      .uop0Src1_o  (slotSrc1_o[UOPS_PER_LANE*g]),
      .uop0Src2_o  (slotSrc2_o[UOPS_PER_LANE*g]),
      .uop0Imm_o   (slotImm_o[UOPS_PER_LANE*g]),
      .uop1Valid_o (slotValid_o[UOPS_PER_LANE*g+1]),
      .uop1Class_o (slotClass_o[UOPS_PER_LANE*g+1]),
      .uop1Dst_o   (slotDst_o[UOPS_PER_LANE*g+1]),
      .uop1Src1_o  (slotSrc1_o[UOPS_PER_LANE*g+1]),
      .uop1Src2_o  (slotSrc2_o[UOPS_PER_LANE*g+1]),
      .uop1Imm_o   (slotImm_o[UOPS_PER_LANE*g+1])
    );

    // both halves of a cracked jump report the jump's pc
    assign slotPc_o[UOPS_PER_LANE*g] = fetchPc_i[g];
    assign slotPc_o[UOPS_PER_LANE*g+1] = fetchPc_i[g];
  end

endmodule

/* logic/instBuffer.sv */
module instBuffer (
  input  logic                                              clk,
  input  logic                                              rstN_i,
  input  logic                                              clear_i,
  input  logic                                              write_i,
  input  logic [frontPkg::SLOT_COUNT-1:0]                   slotValid_i,
  input  frontPkg::uopClassT [frontPkg::SLOT_COUNT-1:0]     slotClass_i,
  input  isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]         slotDst_i,
  input  isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]         slotSrc1_i,
  input  isaPkg::regIdxT [frontPkg::SLOT_COUNT-1:0]         slotSrc2_i,
  input  frontPkg::immT [frontPkg::SLOT_COUNT-1:0]          slotImm_i,
  input  frontPkg::addrT [frontPkg::SLOT_COUNT-1:0]         slotPc_i,
  input  logic                                              dispatchReady_i,
  output logic [frontPkg::DISPATCH_WIDTH-1:0]               dispatchValid_o,
  output frontPkg::uopClassT [frontPkg::DISPATCH_WIDTH-1:0] dispatchClass_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchDst_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchSrc1_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchSrc2_o,
  output frontPkg::immT [frontPkg::DISPATCH_WIDTH-1:0]      dispatchImm_o,
  output frontPkg::addrT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchPc_o,
  output frontPkg::ibCountT                                 freeCount_o
);
  import isaPkg::*;
  import frontPkg::*;

  // entry storage
  uopClassT entryClass [IB_DEPTH];
  regIdxT entryDst [IB_DEPTH];
  regIdxT entrySrc1 [IB_DEPTH];
  regIdxT entrySrc2 [IB_DEPTH];
  immT entryImm [IB_DEPTH];
  addrT entryPc [IB_DEPTH];

  ibPtrT head;
  ibPtrT tail;
  ibCountT count;
  // write slot positions after packing out the holes
  ibPtrT wrIdx [SLOT_COUNT];
  ibCountT wrCount;
  ibCountT rdCount;

  // prefix count of valid slots gives each slot its entry
  always_comb
  begin
    wrCount = '0;
    for (int s = 0; s < SLOT_COUNT; s++)
    begin
      wrIdx[s] = tail + ibPtrT'(wrCount);
      wrCount = wrCount + ibCountT'(slotValid_i[s]);
    end
  end

  // oldest entries at the dispatch ports, valid while occupied
  always_comb
  begin
    rdCount = '0;
    for (int k = 0; k < DISPATCH_WIDTH; k++)
    begin
      dispatchValid_o[k] = (count > ibCountT'(k));
      dispatchClass_o[k] = entryClass[head + ibPtrT'(k)];
      dispatchDst_o[k] = entryDst[head + ibPtrT'(k)];
      dispatchSrc1_o[k] = entrySrc1[head + ibPtrT'(k)];
      dispatchSrc2_o[k] = entrySrc2[head + ibPtrT'(k)];
      dispatchImm_o[k] = entryImm[head + ibPtrT'(k)];
      dispatchPc_o[k] = entryPc[head + ibPtrT'(k)];
      // retire only what was offered
      if (dispatchReady_i && dispatchValid_o[k])
      begin
        rdCount = rdCount + 1'b1;
      end
    end
  end

  // pointers and occupancy, clear wins over write and retire
  always_ff @(posedge clk)
  begin
    if (!rstN_i || clear_i)
    begin
      head <= '0;
      tail <= '0;
      count <= '0;
    end
    else
    begin
      head <= head + ibPtrT'(rdCount);
      if (write_i)
      begin
        tail <= tail + ibPtrT'(wrCount);
        count <= count + wrCount - rdCount;
      end
      else
      begin
        count <= count - rdCount;
      end
    end
  end

  // payload write, slots land in program order from the tail
  always_ff @(posedge clk)
  begin
    if (write_i)
    begin
      for (int s = 0; s < SLOT_COUNT; s++)
      begin
        if (slotValid_i[s])
        begin
          entryClass[wrIdx[s]] <= slotClass_i[s];
          entryDst[wrIdx[s]] <= slotDst_i[s];
          entrySrc1[wrIdx[s]] <= slotSrc1_i[s];
          entrySrc2[wrIdx[s]] <= slotSrc2_i[s];
          entryImm[wrIdx[s]] <= slotImm_i[s];
          entryPc[wrIdx[s]] <= slotPc_i[s];
        end
      end
    end
  end

  // free space seen by the ready logic
  assign freeCount_o = ibCountT'(IB_DEPTH) - count;

endmodule

/* logic/decodeCtrl.sv */
module decodeCtrl (
  input  logic              clk,
  input  logic              rstN_i,
  input  logic              flush_i,
  input  frontPkg::ibCountT freeCount_i,
  output logic              decodeReady_o,
  output logic              bufClear_o
);
  import frontPkg::*;

  ctrlStateT state;
  ctrlStateT stateNext;

  always_comb
  begin
    stateNext = state;
    case (state)
      // one cycle of clearing, then run
      CTRL_FLUSH: stateNext = CTRL_RUN;
      CTRL_RUN: stateNext = CTRL_RUN;
      default: stateNext = CTRL_FLUSH;
    endcase
    // flush restarts the sequence from any state
    if (flush_i)
    begin
      stateNext = CTRL_FLUSH;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      state <= CTRL_FLUSH;
    end
    else
    begin
      state <= stateNext;
    end
  end

  // clear on the flush edge itself so the buffer is empty right after
  assign bufClear_o = flush_i || (state == CTRL_FLUSH);
  // whole bundle must fit, no partial accept
  assign decodeReady_o = (state == CTRL_RUN) && (freeCount_i >= ibCountT'(SLOT_COUNT));

endmodule

/* logic/frontDecodeTop.sv */
module frontDecodeTop (
  input  logic                                              clk,
  input  logic                                              rstN_i,
  input  logic                                              fetchValid_i,
  input  frontPkg::addrT [frontPkg::FETCH_WIDTH-1:0]        fetchPc_i,
  input  isaPkg::instrT [frontPkg::FETCH_WIDTH-1:0]         fetchInstr_i,
  input  logic [frontPkg::FETCH_WIDTH-1:0]                  laneActive_i,
  input  logic                                              dispatchReady_i,
  input  logic                                              flush_i,
  output logic                                              decodeReady_o,
  output logic [frontPkg::DISPATCH_WIDTH-1:0]               dispatchValid_o,
  output frontPkg::uopClassT [frontPkg::DISPATCH_WIDTH-1:0] dispatchClass_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchDst_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchSrc1_o,
  output isaPkg::regIdxT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchSrc2_o,
  output frontPkg::immT [frontPkg::DISPATCH_WIDTH-1:0]      dispatchImm_o,
  output frontPkg::addrT [frontPkg::DISPATCH_WIDTH-1:0]     dispatchPc_o
);
  import isaPkg::*;
  import frontPkg::*;

  // decode slots toward the buffer
  logic [SLOT_COUNT-1:0] slotValid;
  uopClassT [SLOT_COUNT-1:0] slotClass;
  regIdxT [SLOT_COUNT-1:0] slotDst;
  regIdxT [SLOT_COUNT-1:0] slotSrc1;
  regIdxT [SLOT_COUNT-1:0] slotSrc2;
  immT [SLOT_COUNT-1:0] slotImm;
  addrT [SLOT_COUNT-1:0] slotPc;
  ibCountT freeCount;
  logic bufClear;
  logic bufWrite;

  // bundle accepted when both sides agree
  assign bufWrite = fetchValid_i & decodeReady_o;

  decodeCtrl decodeCtrl_i (
    .clk           (clk),
    .rstN_i        (rstN_i),
    .flush_i       (flush_i),
    .freeCount_i   (freeCount),
    .decodeReady_o (decodeReady_o),
    .bufClear_o    (bufClear)
  );

  decodeStage decodeStage_i (
    .fetchValid_i (fetchValid_i),
    .laneActive_i (laneActive_i),
    .fetchPc_i    (fetchPc_i),
    .fetchInstr_i (fetchInstr_i),
    .slotValid_o  (slotValid),
    .slotClass_o  (slotClass),
    .slotDst_o    (slotDst),
    .slotSrc1_o   (slotSrc1),
    .slotSrc2_o   (slotSrc2),
    .slotImm_o    (slotImm),
    .slotPc_o     (slotPc)
  );

  instBuffer instBuffer_i (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .clear_i         (bufClear),
    .write_i         (bufWrite),
    .slotValid_i     (slotValid),
    .slotClass_i     (slotClass),
    .slotDst_i       (slotDst),
    .slotSrc1_i      (slotSrc1),
    .slotSrc2_i      (slotSrc2),
    .slotImm_i       (slotImm),
    .slotPc_i        (slotPc),
    .dispatchReady_i (dispatchReady_i),
    .dispatchValid_o (dispatchValid_o),
    .dispatchClass_o (dispatchClass_o),
    .dispatchDst_o   (dispatchDst_o),
    .dispatchSrc1_o  (dispatchSrc1_o),
    .dispatchSrc2_o  (dispatchSrc2_o),
    .dispatchImm_o   (dispatchImm_o),
    .dispatchPc_o    (dispatchPc_o),
    .freeCount_o     (freeCount)
  );

endmodule

/* testbench/clockGen.sv */
module clockGen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period, first rising edge at 4 ns
  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #4 clk_o = ~clk_o;
    end
  end

endmodule

/* testbench/frontDecode_props.sv */
module frontDecodeProps (
  input logic                                clk,
  input logic                                rstN_i,
  input logic                                write_i,
  input frontPkg::ibCountT                   count_i,
  input frontPkg::ibCountT                   freeCount_i,
  input logic [frontPkg::DISPATCH_WIDTH-1:0] dispatchValid_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import frontPkg::*;

  // failed property count read by the testbench at the end of the run
  int failCount = 0;

  // occupancy stays within the entry count
  countBound: assert property (@(posedge clk) disable iff (!rstN_i)
    count_i <= ibCountT'(IB_DEPTH))
    else
    begin
      $error("instBuffer count above depth");
      failCount++;
    end

  // a whole bundle must fit before any write
  writeFits: assert property (@(posedge clk) disable iff (!rstN_i)
    write_i |-> freeCount_i >= ibCountT'(SLOT_COUNT))
    else
    begin
      $error("instBuffer written with less than one bundle of space");
      failCount++;
    end

  // slot 1 only valid behind slot 0
  validOrder: assert property (@(posedge clk) disable iff (!rstN_i)
    dispatchValid_i[1] |-> dispatchValid_i[0])
    else
    begin
      $error("dispatch valids not contiguous");
      failCount++;
    end

endmodule

bind instBuffer frontDecodeProps frontDecodeProps_i (
  .clk             (clk),
  .rstN_i          (rstN_i),
  .write_i         (write_i),
  .count_i         (count),
  .freeCount_i     (freeCount_o),
  .dispatchValid_i (dispatchValid_o)
);

/* testbench/frontDecodeTb.sv */
module frontDecodeTb;
  timeunit 1ns;
  timeprecision 100ps;
  import isaPkg::*;
  import frontPkg::*;

  // instruction kinds to encode
  // the 0 forms force rd to x0
  localparam int K_ADDI = 0;
  localparam int K_ADD = 1;
  localparam int K_LUI = 2;
  localparam int K_LOAD = 3;
  localparam int K_STORE = 4;
  localparam int K_BRANCH = 5;
  localparam int K_JAL = 6;
  localparam int K_JALR = 7;
  localparam int K_ILLEGAL = 8;
  localparam int K_JAL0 = 9;
  localparam int K_JALR0 = 10;
  // six tests of well under 300 cycles each
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int WAIT_LIMIT = 100;

  typedef struct packed {
    uopClassT cls;
    regIdxT dst;
    regIdxT src1;
    regIdxT src2;
    immT imm;
    addrT pc;
  } uopExpT;

  logic clk;
  logic rstN;
  logic fetchValid;
  addrT [FETCH_WIDTH-1:0] fetchPc;
  instrT [FETCH_WIDTH-1:0] fetchInstr;
  logic [FETCH_WIDTH-1:0] laneActive;
  logic dispatchReady;
  logic flush;
  logic decodeReady;
  logic [DISPATCH_WIDTH-1:0] dispatchValid;
  uopClassT [DISPATCH_WIDTH-1:0] dispatchClass;
  regIdxT [DISPATCH_WIDTH-1:0] dispatchDst;
  regIdxT [DISPATCH_WIDTH-1:0] dispatchSrc1;
  regIdxT [DISPATCH_WIDTH-1:0] dispatchSrc2;
  immT [DISPATCH_WIDTH-1:0] dispatchImm;
  addrT [DISPATCH_WIDTH-1:0] dispatchPc;

  // expected uops in program order and the uops of the bundle being sent
  uopExpT expQ[$];
  uopExpT stagedQ[$];
  addrT pcNext;
  int errCount = 0;
  int testCount = 0;
  int failCount = 0;
  int propFails = 0;
  int cycles = 0;

  clockGen clockGen_i (
    .clk_o (clk)
  );

  frontDecodeTop frontDecodeTop_i (
    .clk             (clk),
    .rstN_i          (rstN),
    .fetchValid_i    (fetchValid),
    .fetchPc_i       (fetchPc),
    .fetchInstr_i    (fetchInstr),
    .laneActive_i    (laneActive),
    .dispatchReady_i (dispatchReady),
    .flush_i         (flush),
    .decodeReady_o   (decodeReady),
    .dispatchValid_o (dispatchValid),
    .dispatchClass_o (dispatchClass),
    .dispatchDst_o   (dispatchDst),
    .dispatchSrc1_o  (dispatchSrc1),
    .dispatchSrc2_o  (dispatchSrc2),
    .dispatchImm_o   (dispatchImm),
    .dispatchPc_o    (dispatchPc)
  );

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      errCount++;
    end
  endtask

  // encode one instruction and stage the uops the decode rules predict
  task automatic encodeLane(input int kind, input immT imm, input addrT pc,
                            input logic keep, output instrT instr);
    regIdxT rd;
    regIdxT rs1;
    regIdxT rs2;
    uopExpT u;
    uopExpT link;
    rd = regIdxT'($urandom_range(31, 1));
    rs1 = regIdxT'($urandom);
    rs2 = regIdxT'($urandom);
    if (kind == K_JAL0 || kind == K_JALR0)
    begin
      rd = '0;
    end
    u = '0;
    u.pc = pc;
    u.imm = imm;
    link = '0;
    case (kind)
      K_ADDI:
      begin
        instr = {imm[11:0], rs1, 3'b000, rd, OP_IMM};
        u.cls = UOP_ALU;
        u.dst = rd;
        u.src1 = rs1;
      end
      K_ADD:
      begin
        instr = {7'b0, rs2, rs1, 3'b000, rd, OP_REG};
        u.cls = UOP_ALU;
        u.dst = rd;
        u.src1 = rs1;
        u.src2 = rs2;
        u.imm = '0;
      end
      K_LUI:
      begin
        instr = {imm[31:12], rd, OP_LUI};
        u.cls = UOP_ALU;
        u.dst = rd;
        u.imm = {imm[31:12], 12'b0};
      end
      K_LOAD:
      begin
        instr = {imm[11:0], rs1, 3'b010, rd, OP_LOAD};
        u.cls = UOP_LOAD;
        u.dst = rd;
        u.src1 = rs1;
      end
      K_STORE:
      begin
        instr = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
        u.cls = UOP_STORE;
        u.src1 = rs1;
        u.src2 = rs2;
      end
      K_BRANCH:
      begin
        instr = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
        u.cls = UOP_BRANCH;
        u.src1 = rs1;
        u.src2 = rs2;
      end
      K_JAL, K_JAL0, K_JALR, K_JALR0:
      begin
        if (kind == K_JAL || kind == K_JAL0)
        begin
          instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
        end
        else
        begin
          instr = {imm[11:0], rs1, 3'b000, rd, OP_JALR};
          u.src1 = rs1;
        end
        u.cls = UOP_JUMP;
        // nonzero rd cracks off a link uop first
        link.cls = UOP_LINK;
        link.dst = rd;
        link.imm = 32'd4;
        link.pc = pc;
        if (keep && rd != '0)
        begin
          stagedQ.push_back(link);
        end
      end
      default:
      begin
        // custom-0 opcode is not part of RV32I
        instr = {12'h000, rs1, 3'b000, rd, 7'b0001011};
        u.cls = UOP_ILLEGAL;
        u.imm = '0;
      end
    endcase
    if (keep)
    begin
      stagedQ.push_back(u);
    end
  endtask

  // present one bundle and wait for the accepting edge
  task automatic sendBundle(input int kind0, input immT imm0, input int kind1,
                            input immT imm1, input logic [FETCH_WIDTH-1:0] mask);
    instrT instr0;
    instrT instr1;
    int waited;
    logic accepted;
    stagedQ.delete();
    encodeLane(kind0, imm0, pcNext, mask[0], instr0);
    encodeLane(kind1, imm1, pcNext + 32'd4, mask[1], instr1);
    @(negedge clk);
    fetchPc = {pcNext + 32'd4, pcNext};
    fetchInstr = {instr1, instr0};
    laneActive = mask;
    fetchValid = 1'b1;
    waited = 0;
    do
    begin
      @(posedge clk);
      accepted = decodeReady;
      waited++;
    end
    while (!accepted && waited < WAIT_LIMIT);
    assert (accepted)
    else
    begin
      $display("bundle at pc 0x%0h not accepted within %0d cycles", pcNext, WAIT_LIMIT);
      errCount++;
    end
    if (accepted)
    begin
      foreach (stagedQ[i])
      begin
        expQ.push_back(stagedQ[i]);
      end
    end
    pcNext = pcNext + 32'd8;
    @(negedge clk);
    fetchValid = 1'b0;
  endtask

  // wait until every expected uop has been dispatched
  task automatic waitDrain();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    assert (expQ.size() == 0)
    else
    begin
      $display("%0d expected micro-ops never dispatched", expQ.size());
      errCount++;
      expQ.delete();
    end
    repeat (2) @(negedge clk);
    checkValue("dispatchValid_o", dispatchValid, 32'd0);
  endtask

  task automatic finishTest(input string name, input int errBefore);
    testCount++;
    if (errCount != errBefore)
    begin
      failCount++;
      $display("test %0d %s: FAIL, %0d errors", testCount, name, errCount - errBefore);
    end
    else
    begin
      $display("test %0d %s: ok", testCount, name);
    end
  endtask

  // every dispatched uop against the head of the expected queue
  always @(posedge clk)
  begin
    if (rstN)
    begin
      for (int k = 0; k < DISPATCH_WIDTH; k++)
      begin
        if (dispatchValid[k] && dispatchReady)
        begin
          assert (expQ.size() > 0)
          else
          begin
            $display("unexpected micro-op at dispatch slot %0d, pc 0x%0h", k, dispatchPc[k]);
            errCount++;
          end
          if (expQ.size() > 0)
          begin
            checkValue($sformatf("dispatchClass_o[%0d]", k), dispatchClass[k], expQ[0].cls);
            checkValue($sformatf("dispatchDst_o[%0d]", k), dispatchDst[k], expQ[0].dst);
            checkValue($sformatf("dispatchSrc1_o[%0d]", k), dispatchSrc1[k], expQ[0].src1);
            checkValue($sformatf("dispatchSrc2_o[%0d]", k), dispatchSrc2[k], expQ[0].src2);
            checkValue($sformatf("dispatchImm_o[%0d]", k), dispatchImm[k], expQ[0].imm);
            checkValue($sformatf("dispatchPc_o[%0d]", k), dispatchPc[k], expQ[0].pc);
            void'(expQ.pop_front());
          end
        end
      end
    end
  end

  task automatic basicOps();
    int errBefore;
    errBefore = errCount;
    sendBundle(K_ADDI, 32'd100, K_ADD, 32'd0, 2'b11);
    sendBundle(K_LUI, 32'hABCDE000, K_LOAD, -32'sd8, 2'b11);
    sendBundle(K_STORE, 32'd2047, K_BRANCH, -32'sd4096, 2'b11);
    sendBundle(K_ADDI, -32'sd2048, K_LOAD, 32'd12, 2'b11);
    waitDrain();
    finishTest("alu load store branch", errBefore);
  endtask

  task automatic jumpCracking();
    int errBefore;
    errBefore = errCount;
    sendBundle(K_JAL, 32'd2048, K_JALR, -32'sd16, 2'b11);
    sendBundle(K_JAL0, -32'sd1048576, K_JALR0, 32'd40, 2'b11);
    sendBundle(K_ADDI, 32'd1, K_JAL, 32'h000FFFFE, 2'b11);
    waitDrain();
    finishTest("jal jalr cracking", errBefore);
  endtask

  task automatic laneMasking();
    int errBefore;
    errBefore = errCount;
    sendBundle(K_ADDI, 32'd7, K_JAL, 32'd64, 2'b10);
    sendBundle(K_JALR, 32'd4, K_STORE, 32'd20, 2'b01);
    sendBundle(K_ADD, 32'd0, K_ADD, 32'd0, 2'b00);
    sendBundle(K_LOAD, -32'sd4, K_BRANCH, 32'd8, 2'b11);
    waitDrain();
    finishTest("lane mask", errBefore);
  endtask

  task automatic backPressure();
    int errBefore;
    errBefore = errCount;
    @(negedge clk);
    dispatchReady = 1'b0;
    // four cracked bundles fill all 16 entries
    repeat (4) sendBundle(K_JAL, 32'd256, K_JALR, 32'd8, 2'b11);
    checkValue("decodeReady_o", decodeReady, 32'd0);
    fork
      sendBundle(K_ADDI, 32'd3, K_ADD, 32'd0, 2'b11);
      begin
        repeat (3)
        begin
          @(negedge clk);
          checkValue("decodeReady_o", decodeReady, 32'd0);
        end
        dispatchReady = 1'b1;
      end
    join
    waitDrain();
    finishTest("back-pressure", errBefore);
  endtask

  task automatic flushBuffer();
    int errBefore;
    errBefore = errCount;
    @(negedge clk);
    dispatchReady = 1'b0;
    sendBundle(K_ADDI, 32'd5, K_LOAD, 32'd16, 2'b11);
    sendBundle(K_JAL, 32'd32, K_STORE, 32'd4, 2'b11);
    checkValue("dispatchValid_o", dispatchValid, 32'd3);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    // flushed uops will never reach dispatch
    expQ.delete();
    checkValue("dispatchValid_o", dispatchValid, 32'd0);
    checkValue("decodeReady_o", decodeReady, 32'd0);
    @(negedge clk);
    checkValue("decodeReady_o", decodeReady, 32'd1);
    dispatchReady = 1'b1;
    sendBundle(K_ADD, 32'd0, K_BRANCH, -32'sd2, 2'b11);
    waitDrain();
    finishTest("flush", errBefore);
  endtask

  task automatic illegalOpcode();
    int errBefore;
    errBefore = errCount;
    sendBundle(K_ILLEGAL, 32'd0, K_ADDI, 32'd9, 2'b11);
    sendBundle(K_ADD, 32'd0, K_ILLEGAL, 32'd0, 2'b11);
    waitDrain();
    finishTest("illegal opcode", errBefore);
  endtask

  // run limit
  initial
  begin
    while (cycles < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run passed %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial
  begin
    void'($urandom(13585));
    rstN = 1'b0;
    fetchValid = 1'b0;
    fetchPc = '0;
    fetchInstr = '0;
    laneActive = '1;
    dispatchReady = 1'b1;
    flush = 1'b0;
    pcNext = 32'h0000_1000;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    basicOps();
    jumpCracking();
    laneMasking();
    backPressure();
    flushBuffer();
    illegalOpcode();
    propFails = frontDecodeTop_i.instBuffer_i.frontDecodeProps_i.failCount;
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             testCount, failCount, errCount, propFails);
    if (errCount == 0 && propFails == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/isaPkg.sv
logic/frontPkg.sv
logic/decodeLane.sv
logic/decodeStage.sv
logic/instBuffer.sv
logic/decodeCtrl.sv
logic/frontDecodeTop.sv
testbench/clockGen.sv
testbench/frontDecode_props.sv
testbench/frontDecodeTb.sv
